// ==== rtl/sound_map_pkg.sv ====
// sound cpu memory map, bus widths and boot command codes
package sound_map_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus widths

	localparam int z80_addr_width = 16;	// sound cpu address bus
	localparam int z80_data_width = 8;	// sound cpu data bus
	localparam int ram_addr_width = 11;	// 2k work ram words

	//////////////////////////////////////////////////////////////////////
	// memory regions, inclusive bounds

	localparam logic [z80_addr_width-1:0] rom_base  = 16'h0000;	// fixed program rom
	localparam logic [z80_addr_width-1:0] rom_last  = 16'h7FFF;
	localparam logic [z80_addr_width-1:0] bank_base = 16'h8000;	// switched rom window
	localparam logic [z80_addr_width-1:0] bank_last = 16'hBFFF;
	localparam logic [z80_addr_width-1:0] ram_base  = 16'hD000;	// work ram
	localparam logic [z80_addr_width-1:0] ram_last  = 16'hD7FF;

	//////////////////////////////////////////////////////////////////////
	// io registers, each one a pair of bytes (a0 picks within the pair)

	localparam logic [z80_addr_width-1:0] fm_reg_addr   = 16'hF000;	// fm chip, F000/F001
	localparam logic [z80_addr_width-1:0] pcm_reg_addr  = 16'hF002;	// pcm chip, F002/F003
	localparam logic [z80_addr_width-1:0] bank_reg_addr = 16'hF004;	// rom bank bit
	localparam logic [z80_addr_width-1:0] cmd_reg_addr  = 16'hF008;	// sound command latch

	// pcm chip is never read back for real
	localparam logic [z80_data_width-1:0] pcm_status_idle = 8'hF0;	// all voices idle

	//////////////////////////////////////////////////////////////////////
	// boot command codes

	localparam logic [z80_data_width-1:0] cmd_silence      = 8'hF0;	// stop everything
	localparam logic [z80_data_width-1:0] cmd_idle         = 8'hFF;	// no command pending
	localparam logic [z80_data_width-1:0] cmd_music_select = 8'hF7;	// next byte is a tune

endpackage

// ==== rtl/audio_pkg.sv ====
// audio sample widths and the pcm output word with its two decodes
package audio_pkg;

	//////////////////////////////////////////////////////////////////////
	// sample widths, all two's complement

	localparam int fm_width    = 16;	// fm synth per-channel sample
	localparam int pcm_width   = 22;	// pcm summed voice output
	localparam int audio_width = 16;	// board output sample

	//////////////////////////////////////////////////////////////////////
	// pcm word
	//
	// The PCM chip gives one 22-bit mono sum. The left channel takes a
	// wide 17-bit slice from the top, the right channel a 16-bit slice
	// two bits lower, so the channels get a different gain. Both views
	// decode the same bits.

	typedef union packed {
		struct packed {
			logic signed [16:0] val;	// bits 21..5
			logic [4:0]         drop;	// below the left resolution
		} left;
		struct packed {
			logic [1:0]         guard;	// bits 21..20, discarded
			logic signed [15:0] val;	// bits 19..4
			logic [3:0]         drop;	// below the right resolution
		} right;
	} pcm_word_u;

endpackage

// ==== rtl/z80_bus_decode.sv ====
// sound cpu address decode, banked rom address, chip strobes and read mux
`timescale 1ns/100ps

module z80_bus_decode (
	input  logic [sound_map_pkg::z80_addr_width-1:0] z80_addr,	// cpu address
	input  logic                                     z80_rd_n,
	input  logic                                     z80_wr_n,
	input  logic                                     z80_mreq_n,
	input  logic                                     bank,	// rom bank bit
	input  logic [sound_map_pkg::z80_data_width-1:0] rom_data,	// external rom
	input  logic [sound_map_pkg::z80_data_width-1:0] ram_rdata,	// work ram, registered
	input  logic [sound_map_pkg::z80_data_width-1:0] fm_rdata,	// fm status
	input  logic [sound_map_pkg::z80_data_width-1:0] cmd,	// command latch
	output logic [sound_map_pkg::z80_addr_width-1:0] rom_addr,
	output logic                                     ram_we,
	output logic                                     bank_we,
	output logic                                     fm_cs_n,
	output logic                                     fm_wr_n,
	output logic                                     fm_a0,
	output logic                                     pcm_cs_n,
	output logic                                     pcm_rd_n,
	output logic                                     pcm_wr_n,
	output logic [sound_map_pkg::z80_data_width-1:0] z80_din	// read data to cpu
);
	import sound_map_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// region selects

	logic rom_sel;	// 0000-7FFF
	logic bank_sel;	// 8000-BFFF
	logic ram_sel;	// D000-D7FF
	logic fm_sel;
	logic pcm_sel;
	logic bank_reg_sel;
	logic cmd_sel;
	logic mem_rd;	// mreq with rd
	logic mem_wr;	// mreq with wr

	assign rom_sel  = (z80_addr >= rom_base) && (z80_addr <= rom_last);
	assign bank_sel = (z80_addr >= bank_base) && (z80_addr <= bank_last);
	assign ram_sel  = (z80_addr >= ram_base) && (z80_addr <= ram_last);

	// io registers decode as byte pairs
	assign fm_sel       = z80_addr[z80_addr_width-1:1] == fm_reg_addr[z80_addr_width-1:1];
	assign pcm_sel      = z80_addr[z80_addr_width-1:1] == pcm_reg_addr[z80_addr_width-1:1];
	assign bank_reg_sel = z80_addr[z80_addr_width-1:1] == bank_reg_addr[z80_addr_width-1:1];
	assign cmd_sel      = z80_addr[z80_addr_width-1:1] == cmd_reg_addr[z80_addr_width-1:1];

	assign mem_rd = !z80_mreq_n && !z80_rd_n;
	assign mem_wr = !z80_mreq_n && !z80_wr_n;

	//////////////////////////////////////////////////////////////////////
	// rom address

	always_comb begin
		if (bank_sel)
			rom_addr = {1'b1, bank, z80_addr[13:0]};	// window into upper 32k
		else
			rom_addr = z80_addr;	// fixed region straight through
	end

	//////////////////////////////////////////////////////////////////////
	// write enables and chip strobes

	assign ram_we  = ram_sel && mem_wr;
	assign bank_we = bank_reg_sel && mem_wr;

	assign fm_cs_n = !(fm_sel && (mem_rd || mem_wr));	// idle high between accesses
	assign fm_wr_n = !(fm_sel && mem_wr);
	assign fm_a0   = z80_addr[0];	// register / data port select

	assign pcm_cs_n = !(pcm_sel && (mem_rd || mem_wr));
	assign pcm_rd_n = !(pcm_sel && mem_rd);
	assign pcm_wr_n = !(pcm_sel && mem_wr);

	//////////////////////////////////////////////////////////////////////
	// read data, first match wins

	always_comb begin
		if (rom_sel || bank_sel)
			z80_din = rom_data;
		else if (ram_sel)
			z80_din = ram_rdata;
		else if (fm_sel)
			z80_din = fm_rdata;
		else if (pcm_sel)
			z80_din = pcm_status_idle;	// no voices ever busy
		else if (cmd_sel)
			z80_din = cmd;
		else
			z80_din = '0;	// unmapped, fade latch included
	end

endmodule

// ==== rtl/z80_work_ram.sv ====
// sound cpu work ram, 2k x 8, write on strobe, registered read
`timescale 1ns/100ps

module z80_work_ram (
	input  logic                                     clk_sys,
	input  logic [sound_map_pkg::ram_addr_width-1:0] addr,	// low address bits
	input  logic [sound_map_pkg::z80_data_width-1:0] wdata,
	input  logic                                     we,
	output logic [sound_map_pkg::z80_data_width-1:0] rdata	// one clock behind addr
);
	import sound_map_pkg::*;

	localparam int depth = 2 ** ram_addr_width;	// 2048 bytes

	logic [z80_data_width-1:0] mem [depth];	// inferred block ram

	// write port
	always_ff @(posedge clk_sys) begin
		if (we)
			mem[addr] <= wdata;
	end

	// read port, old data on a same-address write
	always_ff @(posedge clk_sys) begin
		rdata <= mem[addr];
	end

endmodule

// ==== rtl/sound_latches.sv ====
// rom bank register and self-running boot command sequencer
`timescale 1ns/100ps

module sound_latches #(
	parameter int                                     boot_delay_bits = 16,	// gap between commands
	parameter logic [sound_map_pkg::z80_data_width-1:0] boot_tune       = 8'h0A	// tune to start
) (
	input  logic                                     clk_sys,
	input  logic                                     reset,
	input  logic                                     bank_we,	// decoded bank write
	input  logic                                     wdata_bit0,	// cpu data bit 0
	output logic                                     bank,
	output logic [sound_map_pkg::z80_data_width-1:0] cmd	// command latch
);
	import sound_map_pkg::*;

	localparam int boot_steps = 6;	// commands in the boot series

	//////////////////////////////////////////////////////////////////////
	// bank register

	always_ff @(posedge clk_sys) begin
		if (reset)
			bank <= 1'b0;
		else if (bank_we)
			bank <= wdata_bit0;	// level write, held while strobe low
	end

	//////////////////////////////////////////////////////////////////////
	// boot sequencer
	//
	// Stands in for the main CPU, which is not part of this board.
	// A free-running down counter paces the series; each time the
	// count lands on zero the latch takes the next code.

	logic [boot_delay_bits-1:0] delay;	// free-running pace counter
	logic [2:0]                 step;	// 0..6, 6 is done
	logic                       tick;	// counter reaches zero this edge
	logic [z80_data_width-1:0]  next_cmd;	// code for the current step

	assign tick = delay == boot_delay_bits'(1);

	// command table
	always_comb begin
		case (step)
			3'd0:    next_cmd = cmd_silence;
			3'd1:    next_cmd = cmd_idle;
			3'd2:    next_cmd = cmd_music_select;
			3'd3:    next_cmd = cmd_idle;
			3'd4:    next_cmd = boot_tune;	// music number
			3'd5:    next_cmd = cmd_idle;
			default: next_cmd = cmd_idle;	// series over
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			delay <= '1;	// longest wait first
			step  <= 3'd0;
			cmd   <= '0;	// nothing posted yet
		end else begin
			delay <= delay - 1'b1;	// wraps to all ones
			if (tick && (step < 3'(boot_steps))) begin
				cmd  <= next_cmd;
				step <= step + 3'd1;
			end
		end
	end

endmodule

// ==== rtl/audio_mixer.sv ====
// stereo mix of fm and pcm samples, registered, halved to 16 bits
`timescale 1ns/100ps

module audio_mixer (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  logic signed [audio_pkg::fm_width-1:0]  fm_left,
	input  logic signed [audio_pkg::fm_width-1:0]  fm_right,
	input  audio_pkg::pcm_word_u                   pcm_sample,	// mono pcm sum
	output logic signed [audio_pkg::audio_width-1:0] audio_l,
	output logic signed [audio_pkg::audio_width-1:0] audio_r
);
	import audio_pkg::*;

	localparam int sum_width = fm_width + 1;	// one bit of headroom

	logic signed [sum_width-1:0] mix_l;
	logic signed [sum_width-1:0] mix_r;

	// left takes the wide pcm slice, right the lower 16-bit one
	assign mix_l = {fm_left[fm_width-1], fm_left} + pcm_sample.left.val;
	assign mix_r = {fm_right[fm_width-1], fm_right}
		+ {pcm_sample.right.val[15], pcm_sample.right.val};	// sign extend

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_l[sum_width-1:1];	// drop lsb, halves the sum
			audio_r <= mix_r[sum_width-1:1];
		end
	end

endmodule

// ==== rtl/sound_board.sv ====
// sound subsystem top, cpu bus decode, work ram, latches and mixer
`timescale 1ns/100ps

module sound_board #(
	parameter int                                       boot_delay_bits = 16,
	parameter logic [sound_map_pkg::z80_data_width-1:0] boot_tune       = 8'h0A
) (
	input  logic                                       clk_sys,
	input  logic                                       reset,
	input  logic [sound_map_pkg::z80_addr_width-1:0]   z80_addr,
	input  logic [sound_map_pkg::z80_data_width-1:0]   z80_dout,	// cpu write data
	input  logic                                       z80_mreq_n,
	input  logic                                       z80_rd_n,
	input  logic                                       z80_wr_n,
	input  logic [sound_map_pkg::z80_data_width-1:0]   rom_data,
	input  logic [sound_map_pkg::z80_data_width-1:0]   fm_rdata,
	input  logic signed [audio_pkg::fm_width-1:0]      fm_left,
	input  logic signed [audio_pkg::fm_width-1:0]      fm_right,
	input  audio_pkg::pcm_word_u                       pcm_sample,
	output logic [sound_map_pkg::z80_data_width-1:0]   z80_din,
	output logic [sound_map_pkg::z80_addr_width-1:0]   rom_addr,
	output logic                                       fm_cs_n,
	output logic                                       fm_wr_n,
	output logic                                       fm_a0,
	output logic [sound_map_pkg::z80_data_width-1:0]   fm_din,
	output logic                                       pcm_cs_n,
	output logic                                       pcm_rd_n,
	output logic                                       pcm_wr_n,
	output logic [sound_map_pkg::z80_data_width-1:0]   pcm_din,
	output logic signed [audio_pkg::audio_width-1:0]   audio_l,
	output logic signed [audio_pkg::audio_width-1:0]   audio_r
);
	import sound_map_pkg::*;

	logic                      bank;	// rom bank bit
	logic                      bank_we;
	logic                      ram_we;
	logic [z80_data_width-1:0] ram_rdata;
	logic [z80_data_width-1:0] cmd;	// boot command latch

	// both chips take the cpu data bus as is
	assign fm_din  = z80_dout;
	assign pcm_din = z80_dout;

	//////////////////////////////////////////////////////////////////////
	// cpu side

	z80_bus_decode i_decode (
		.z80_addr,
		.z80_rd_n,
		.z80_wr_n,
		.z80_mreq_n,
		.bank,
		.rom_data,
		.ram_rdata,
		.fm_rdata,
		.cmd,
		.rom_addr,
		.ram_we,
		.bank_we,
		.fm_cs_n,
		.fm_wr_n,
		.fm_a0,
		.pcm_cs_n,
		.pcm_rd_n,
		.pcm_wr_n,
		.z80_din
	);

	z80_work_ram i_ram (
		.clk_sys,
		.addr  (z80_addr[ram_addr_width-1:0]),	// D000 window, low bits only
		.wdata (z80_dout),
		.we    (ram_we),
		.rdata (ram_rdata)
	);

	sound_latches #(
		.boot_delay_bits (boot_delay_bits),
		.boot_tune       (boot_tune)
	) i_latches (
		.clk_sys,
		.reset,
		.bank_we,
		.wdata_bit0 (z80_dout[0]),
		.bank,
		.cmd
	);

	//////////////////////////////////////////////////////////////////////
	// audio side

	audio_mixer i_mixer (
		.clk_sys,
		.reset,
		.fm_left,
		.fm_right,
		.pcm_sample,
		.audio_l,
		.audio_r
	);

endmodule

// ==== sim/clock_gen.sv ====
// testbench clock and power-on reset source for clk_sys
`timescale 1ns/100ps

module clock_gen #(
	parameter int period       = 100,	// ns
	parameter int reset_cycles = 8	// rising edges seen in reset
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(period / 2) clk_sys = !clk_sys;	// 50/50 duty
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		@(negedge clk_sys);	// release away from the sampling edge
		reset = 1'b0;
	end

endmodule

// ==== sim/sound_board_checker.sv ====
// bound checks on sound board chip strobes and fixed rom address
`timescale 1ns/100ps

module sound_board_checker (
	input logic                                     clk_sys,
	input logic                                     reset,
	input logic [sound_map_pkg::z80_addr_width-1:0] z80_addr,
	input logic [sound_map_pkg::z80_addr_width-1:0] rom_addr,
	input logic                                     fm_cs_n,
	input logic                                     fm_wr_n,
	input logic                                     pcm_cs_n,
	input logic                                     pcm_rd_n,
	input logic                                     pcm_wr_n
);
	import sound_map_pkg::*;

	int unsigned fault_count = 0;	// failure tally, polled at end of run

	// never both chips at once
	no_dual_select: assert property (@(posedge clk_sys) disable iff (reset)
		fm_cs_n || pcm_cs_n)
	else begin
		$error("fm and pcm chip selects low together");
		fault_count++;
	end

	fm_write_selected: assert property (@(posedge clk_sys) disable iff (reset)
		!fm_wr_n |-> !fm_cs_n)
	else begin
		$error("fm write strobe low without fm chip select");
		fault_count++;
	end

	pcm_strobe_selected: assert property (@(posedge clk_sys) disable iff (reset)
		(!pcm_rd_n || !pcm_wr_n) |-> !pcm_cs_n)
	else begin
		$error("pcm strobe low without pcm chip select");
		fault_count++;
	end

	// lower 32k is never banked
	fixed_rom_passthrough: assert property (@(posedge clk_sys) disable iff (reset)
		(z80_addr < bank_base) |-> (rom_addr == z80_addr))
	else begin
		$error("rom address differs from cpu address in fixed region");
		fault_count++;
	end

endmodule

bind sound_board sound_board_checker i_checker (.*);

// ==== sim/tb_sound_board.sv ====
// directed testbench for the sound board, cpu bus model, rom model and chip stubs
`timescale 1ns/100ps

module tb_sound_board;
	import sound_map_pkg::*;
	import audio_pkg::*;

	localparam int clk_period      = 100;	// ns
	localparam int boot_delay_bits = 6;	// short boot gaps
	localparam int boot_gap        = 2 ** boot_delay_bits;
	localparam int watchdog_clocks = 8 * boot_gap + 2000;

	logic                      clk_sys;
	logic                      reset;
	logic [z80_addr_width-1:0] z80_addr;
	logic [z80_data_width-1:0] z80_dout;
	logic                      z80_mreq_n;
	logic                      z80_rd_n;
	logic                      z80_wr_n;
	logic [z80_data_width-1:0] rom_data;
	logic [z80_data_width-1:0] fm_rdata;
	logic [fm_width-1:0]       fm_left;
	logic [fm_width-1:0]       fm_right;
	logic [pcm_width-1:0]      pcm_sample;	// raw 22-bit word
	logic [z80_data_width-1:0] z80_din;
	logic [z80_addr_width-1:0] rom_addr;
	logic                      fm_cs_n;
	logic                      fm_wr_n;
	logic                      fm_a0;
	logic [z80_data_width-1:0] fm_din;
	logic                      pcm_cs_n;
	logic                      pcm_rd_n;
	logic                      pcm_wr_n;
	logic [z80_data_width-1:0] pcm_din;
	logic [audio_width-1:0]    audio_l;
	logic [audio_width-1:0]    audio_r;
	logic [31:0]               lcg_state = 32'd52;	// seed

	//////////////////////////////////////////////////////////////////////
	// models and helpers

	function automatic logic [7:0] rom_value(input logic [15:0] addr);
		return addr[7:0] ^ addr[15:8];	// low byte xor high byte
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 15);	// fold weak low bits
	endfunction

	// 17-bit sum of sign-extended fm and a 17-bit pcm part, upper 16 kept
	function automatic logic [15:0] mix_sum(input logic [15:0] fm, input logic [16:0] pcm_part);
		logic [16:0] total;
		total = {fm[15], fm} + pcm_part;
		return total[16:1];
	endfunction

	clock_gen #(.period(clk_period), .reset_cycles(8)) i_clock (.clk_sys, .reset);

	sound_board #(.boot_delay_bits(boot_delay_bits)) i_dut (.*);

	assign rom_data = rom_value(rom_addr);	// combinational rom

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s: expected %0h, got %0h", name, expected, actual);
			abort_run();
		end
	endtask

	// strobes low for 3 clocks, returns at the sample point
	task automatic start_access(input logic [15:0] addr, input logic [7:0] data, input bit write);
		@(negedge clk_sys);
		z80_addr   = addr;
		z80_dout   = data;
		z80_mreq_n = 1'b0;
		z80_rd_n   = write;
		z80_wr_n   = !write;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);	// ram word valid here
	endtask

	task automatic end_access();
		@(posedge clk_sys);	// third clock held
		@(negedge clk_sys);
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		start_access(addr, 8'h00, 1'b0);
		data = z80_din;
		end_access();
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		start_access(addr, data, 1'b1);
		end_access();
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests

	task automatic test_boot_sequence();
		logic [7:0] expected [7];
		logic [7:0] value;
		logic [7:0] last;
		int         seen;
		int         polls;
		expected = '{8'h00, cmd_silence, cmd_idle, cmd_music_select, cmd_idle, 8'h0A, cmd_idle};
		bus_read(cmd_reg_addr, value);
		check_value("cmd after reset", expected[0], value);
		last  = value;
		seen  = 1;
		polls = 0;
		while (seen < 7 && polls < 2 * boot_gap) begin	// 4 clocks a poll
			bus_read(cmd_reg_addr, value);
			polls++;
			if (value !== last) begin
				check_value("cmd", expected[seen], value);
				last = value;
				seen++;
			end
		end
		assert (seen == 7) else begin
			$display("boot sequence stopped after %0d of 7 latch values", seen);
			abort_run();
		end
		repeat (boot_gap / 2) begin	// two more gaps, must hold idle
			bus_read(cmd_reg_addr, value);
			check_value("cmd after boot", cmd_idle, value);
		end
	endtask

	task automatic test_work_ram();
		logic [7:0]  model [int];	// last byte written per address
		logic [15:0] addrs [32];
		logic [31:0] rnd;
		logic [7:0]  data;
		for (int i = 0; i < 32; i++) begin
			rnd      = lcg_next();
			addrs[i] = ram_base + rnd[10:0];
			data     = rnd[23:16];
			model[addrs[i]] = data;
			bus_write(addrs[i], data);
		end
		for (int i = 0; i < 32; i++) begin
			bus_read(addrs[i], data);
			check_value("z80_din ram", model[addrs[i]], data);
		end
	endtask

	task automatic test_rom_banking();
		logic [15:0] addr;
		logic [15:0] mapped;
		logic [31:0] rnd;
		logic [7:0]  data;
		for (int i = 0; i < 8; i++) begin	// fixed lower 32k
			rnd  = lcg_next();
			addr = {1'b0, rnd[14:0]};
			bus_read(addr, data);
			check_value("z80_din rom", rom_value(addr), data);
		end
		for (int b = 0; b < 2; b++) begin
			bus_write(bank_reg_addr, 8'(b));
			for (int i = 0; i < 8; i++) begin
				rnd    = lcg_next();
				addr   = {2'b10, rnd[13:0]};	// 8000-BFFF
				mapped = {1'b1, 1'(b), addr[13:0]};
				start_access(addr, 8'h00, 1'b0);
				check_value("rom_addr", mapped, rom_addr);
				check_value("z80_din banked", rom_value(mapped), z80_din);
				end_access();
			end
		end
	endtask

	task automatic test_chip_ports();
		logic [15:0] unmapped [3];
		logic [31:0] rnd;
		logic [7:0]  data;
		unmapped = '{16'hC000, 16'hF006, 16'hF00A};
		rnd = lcg_next();
		start_access(16'hF001, rnd[7:0], 1'b1);	// fm data port
		check_value("fm_a0", 1, fm_a0);
		check_value("fm_din", rnd[7:0], fm_din);
		check_value("fm_cs_n", 0, fm_cs_n);
		check_value("fm_wr_n", 0, fm_wr_n);
		end_access();
		fm_rdata = rnd[15:8];
		start_access(fm_reg_addr, 8'h00, 1'b0);	// fm status read
		check_value("fm_a0", 0, fm_a0);
		check_value("fm_cs_n", 0, fm_cs_n);
		check_value("fm_wr_n", 1, fm_wr_n);
		check_value("z80_din fm", rnd[15:8], z80_din);
		end_access();
		start_access(16'hF003, rnd[23:16], 1'b1);	// pcm write
		check_value("pcm_din", rnd[23:16], pcm_din);
		check_value("pcm_cs_n", 0, pcm_cs_n);
		check_value("pcm_wr_n", 0, pcm_wr_n);
		check_value("pcm_rd_n", 1, pcm_rd_n);
		end_access();
		start_access(pcm_reg_addr, 8'h00, 1'b0);
		check_value("z80_din pcm", 8'hF0, z80_din);
		check_value("pcm_cs_n", 0, pcm_cs_n);
		check_value("pcm_rd_n", 0, pcm_rd_n);
		check_value("pcm_wr_n", 1, pcm_wr_n);
		end_access();
		@(posedge clk_sys);	// bus idle, all chip strobes released
		check_value("fm_cs_n idle", 1, fm_cs_n);
		check_value("fm_wr_n idle", 1, fm_wr_n);
		check_value("pcm_cs_n idle", 1, pcm_cs_n);
		check_value("pcm_rd_n idle", 1, pcm_rd_n);
		check_value("pcm_wr_n idle", 1, pcm_wr_n);
		foreach (unmapped[i]) begin
			bus_read(unmapped[i], data);
			check_value("z80_din unmapped", 8'h00, data);
		end
	endtask

	task automatic test_mixer();
		logic [31:0] rnd;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		for (int i = 0; i < 40; i++) begin
			@(negedge clk_sys);
			rnd        = lcg_next();
			fm_left    = rnd[15:0];
			fm_right   = rnd[31:16];
			rnd        = lcg_next();
			pcm_sample = rnd[21:0];
			exp_l      = mix_sum(fm_left, pcm_sample[21:5]);	// wide slice
			exp_r      = mix_sum(fm_right, {pcm_sample[19], pcm_sample[19:4]});
			@(negedge clk_sys);	// one register stage later
			check_value("audio_l", exp_l, audio_l);
			check_value("audio_r", exp_r, audio_r);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// run

	initial begin
		z80_addr   = '0;
		z80_dout   = '0;
		z80_mreq_n = 1'b1;	// bus idle
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
		fm_rdata   = '0;
		fm_left    = '0;
		fm_right   = '0;
		pcm_sample = '0;
		@(negedge reset);
		test_boot_sequence();	// first, counter runs from reset
		test_work_ram();
		test_rom_banking();
		test_chip_ports();
		test_mixer();
		$display("PASS: all tests");
		$finish;
	end

	// bound checker failures end the run at once
	initial begin
		wait (i_dut.i_checker.fault_count != 0);
		$display("bound assertion on chip strobes or rom address failed");
		abort_run();
	end

	// watchdog
	initial begin
		#(watchdog_clocks * clk_period);
		$display("timeout: tests still running after %0d clocks", watchdog_clocks);
		abort_run();
	end

endmodule

// ==== tb.f ====
rtl/sound_map_pkg.sv
rtl/audio_pkg.sv
rtl/z80_bus_decode.sv
rtl/z80_work_ram.sv
rtl/sound_latches.sv
rtl/audio_mixer.sv
rtl/sound_board.sv
sim/clock_gen.sv
sim/sound_board_checker.sv
sim/tb_sound_board.sv
